/* design/lvdcPkg.sv */
`default_nettype none

package lvdcPkg;

    // memory geometry.
    localparam int addrWidth = 9;
    localparam int memDepth = 512;

    // a word is 26 data bits with two parity bits on top.
    localparam int dataWidth = 26;
    localparam int wordWidth = 28;
    localparam int syllableWidth = 13;

    // timing generator states.
    localparam logic [1:0] phIdle = 2'd0;
    localparam logic [1:0] phA = 2'd1;
    localparam logic [1:0] phB = 2'd2;
    localparam logic [1:0] phC = 2'd3;

    // opcode field values.
    localparam logic [3:0] opHop = 4'd0;
    localparam logic [3:0] opMpy = 4'd1;
    localparam logic [3:0] opSub = 4'd2;
    localparam logic [3:0] opDiv = 4'd3;
    localparam logic [3:0] opTnz = 4'd4;
    localparam logic [3:0] opMph = 4'd5;
    localparam logic [3:0] opAnd = 4'd6;
    localparam logic [3:0] opAdd = 4'd7;
    localparam logic [3:0] opTra = 4'd8;
    localparam logic [3:0] opXor = 4'd9;
    localparam logic [3:0] opPio = 4'd10;
    localparam logic [3:0] opSto = 4'd11;
    localparam logic [3:0] opTmi = 4'd12;
    localparam logic [3:0] opRsu = 4'd13;
    localparam logic [3:0] opShf = 4'd14;
    localparam logic [3:0] opCla = 4'd15;

    typedef struct packed {
        logic [3:0] opcode;
        logic [addrWidth-1:0] operand;
    } syllable_t;

    typedef struct packed {
        syllable_t syl1; // upper half.
        syllable_t syl0;
    } sylPair_t;

    // data word or instruction pair, same 26 bits.
    typedef union packed {
        logic signed [dataWidth-1:0] data;
        sylPair_t syl;
    } lvdcWord_u;

    typedef enum logic [3:0] {
        exNop,
        exAdd,
        exSub,
        exRsu,
        exAnd,
        exXor,
        exCla,
        exSto,
        exTra,
        exTmi,
        exTnz
    } execOp_e;

endpackage

`default_nettype wire

/* design/timingGen.sv */
`timescale 1ns/1ps
`default_nettype none

module timingGen import lvdcPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic runEn,
    input wire logic stepPulse,
    output logic phaseA,
    output logic phaseB,
    output logic phaseC
);

    logic [1:0] state;

    // one instruction is A, B, C; idle between steps.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= phIdle;
        end else begin
            unique case (state)
                phIdle: begin
                    if (runEn || stepPulse) begin
                        state <= phA;
                    end
                end
                phA: begin
                    state <= phB;
                end
                phB: begin
                    state <= phC;
                end
                phC: begin
                    // free run chains straight into the next fetch.
                    if (runEn) begin
                        state <= phA;
                    end else begin
                        state <= phIdle;
                    end
                end
                default: begin
                    state <= phIdle;
                end
            endcase
        end
    end

    // strobes decode straight from the state, so only one is ever high.
    assign phaseA = (state == phA);
    assign phaseB = (state == phB);
    assign phaseC = (state == phC);

endmodule

`default_nettype wire

/* design/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMemory import lvdcPkg::*; (
    input wire logic clk,
    input wire logic phaseA,
    input wire logic [addrWidth-1:0] pcWord,
    input wire logic [addrWidth-1:0] operandAddr,

    input wire logic loadEn,
    input wire logic [addrWidth-1:0] loadAddr,
    input wire logic [wordWidth-1:0] loadWord,

    input wire logic storeStrobe,
    input wire logic [addrWidth-1:0] storeAddr,
    input wire logic [wordWidth-1:0] storeWord,

    output logic [wordWidth-1:0] readWord
);

    logic [wordWidth-1:0] mem [memDepth];
    logic [addrWidth-1:0] readAddr;

    // loader only runs while the machine is stopped.
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadWord; // stored as given, parity included.
        end else if (storeStrobe) begin
            mem[storeAddr] <= storeWord;
        end
    end

    // instruction fetch in phase A, operand access the rest of the time.
    always_comb begin
        if (phaseA) begin
            readAddr = pcWord;
        end else begin
            readAddr = operandAddr;
        end
    end

    assign readWord = mem[readAddr];

endmodule

`default_nettype wire

/* design/syllableDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module syllableDecode import lvdcPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic phaseA,
    input wire logic [wordWidth-1:0] readWord,
    input wire logic pcSyl,
    output execOp_e execOp,
    output logic [addrWidth-1:0] operandAddr
);

    lvdcWord_u fetched;
    syllable_t curSyl;

    // parity bits play no part in decode.
    assign fetched = readWord[dataWidth-1:0];

    // instruction register, cleared to HOP so reset decodes as a no-op.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            curSyl <= '0;
        end else if (phaseA) begin
            if (pcSyl) begin
                curSyl <= fetched.syl.syl1;
            end else begin
                curSyl <= fetched.syl.syl0;
            end
        end
    end

    always_comb begin
        unique case (curSyl.opcode)
            opAdd: execOp = exAdd;
            opSub: execOp = exSub;
            opRsu: execOp = exRsu;
            opAnd: execOp = exAnd;
            opXor: execOp = exXor;
            opCla: execOp = exCla;
            opSto: execOp = exSto;
            opTra: execOp = exTra;
            opTmi: execOp = exTmi;
            opTnz: execOp = exTnz;
            // multiply/divide, I/O and shift units are not built.
            opHop, opMpy, opDiv, opMph, opPio, opShf: begin
                execOp = exNop;
            end
            default: execOp = exNop;
        endcase
    end

    assign operandAddr = curSyl.operand;

endmodule

`default_nettype wire

/* design/bufferRegister.sv */
`timescale 1ns/1ps
`default_nettype none

module bufferRegister import lvdcPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic phaseB,
    input wire logic phaseC,
    input wire logic [wordWidth-1:0] readWord,
    input wire execOp_e execOp,
    input wire logic [addrWidth-1:0] operandAddr,
    input wire logic [dataWidth-1:0] acc,
    output logic [dataWidth-1:0] operandData,
    output logic parityError,
    output logic storeStrobe,
    output logic [addrWidth-1:0] storeAddr,
    output logic [wordWidth-1:0] storeWord
);

    lvdcWord_u inWord;
    lvdcWord_u accWord;
    logic [1:0] inParity;
    logic usesOperand;
    logic parityBad;

    // bit that makes the 14-bit group odd.
    function automatic logic oddParity(input logic [syllableWidth-1:0] syl);
        return ~^syl;
    endfunction

    assign inWord = readWord[dataWidth-1:0];
    assign inParity = readWord[wordWidth-1:dataWidth]; // {syl1, syl0} parity.
    assign accWord = acc;

    // only instructions that consume the operand read it in phase B.
    always_comb begin
        unique case (execOp)
            exAdd, exSub, exRsu, exAnd, exXor, exCla: usesOperand = 1'b1;
            default: usesOperand = 1'b0;
        endcase
    end

    assign parityBad = (inParity[1] != oddParity(inWord.syl.syl1)) ||
                       (inParity[0] != oddParity(inWord.syl.syl0));

    always_ff @(posedge clk) begin
        if (phaseB) begin
            operandData <= inWord.data;
        end
    end

    // sticky until reset.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            parityError <= 1'b0;
        end else if (phaseB && usesOperand && parityBad) begin
            parityError <= 1'b1;
        end
    end

    // store path, written by memory at the end of phase C.
    assign storeStrobe = phaseC && (execOp == exSto);
    assign storeAddr = operandAddr;
    assign storeWord = {oddParity(accWord.syl.syl1), oddParity(accWord.syl.syl0), accWord.data};

endmodule

`default_nettype wire

/* design/arithExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module arithExecute import lvdcPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic phaseC,
    input wire execOp_e execOp,
    input wire logic [addrWidth-1:0] operandAddr,
    input wire logic [dataWidth-1:0] operandData,
    output logic [dataWidth-1:0] acc,
    output logic [addrWidth-1:0] pcWord,
    output logic pcSyl
);

    logic [dataWidth-1:0] accNext;
    logic takeJump;

    // all results wrap at 26 bits, there is no overflow flag.
    always_comb begin
        unique case (execOp)
            exAdd: accNext = acc + operandData;
            exSub: accNext = acc - operandData;
            exRsu: accNext = operandData - acc; // reverse subtract.
            exAnd: accNext = acc & operandData;
            exXor: accNext = acc ^ operandData;
            exCla: accNext = operandData;
            default: accNext = acc;
        endcase
    end

    // branch conditions look at acc before this instruction.
    always_comb begin
        unique case (execOp)
            exTra: takeJump = 1'b1;
            exTmi: takeJump = acc[dataWidth-1];
            exTnz: takeJump = |acc;
            default: takeJump = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            acc <= '0;
        end else if (phaseC) begin
            acc <= accNext;
        end
    end

    // syllable 0 then 1 of each word; jumps land on syllable 0.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcWord <= '0;
            pcSyl <= 1'b0;
        end else if (phaseC) begin
            if (takeJump) begin
                pcWord <= operandAddr;
                pcSyl <= 1'b0;
            end else if (pcSyl) begin
                pcWord <= pcWord + 1'b1; // wraps at the top of memory.
                pcSyl <= 1'b0;
            end else begin
                pcSyl <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/lvdcCore.sv */
`timescale 1ns/1ps
`default_nettype none

module lvdcCore import lvdcPkg::*; (
    input wire logic clk,
    input wire logic rstN,
    input wire logic runEn,
    input wire logic stepPulse,
    input wire logic loadEn,
    input wire logic [addrWidth-1:0] loadAddr,
    input wire logic [wordWidth-1:0] loadWord,
    output logic phaseC,
    output logic [dataWidth-1:0] acc,
    output logic [addrWidth-1:0] pcWord,
    output logic pcSyl,
    output logic storeStrobe,
    output logic [addrWidth-1:0] storeAddr,
    output logic [wordWidth-1:0] storeWord,
    output logic parityError
);

    logic phaseA;
    logic phaseB;
    logic [wordWidth-1:0] readWord;
    execOp_e execOp;
    logic [addrWidth-1:0] operandAddr;
    logic [dataWidth-1:0] operandData;

    timingGen timing0 (
        .clk(clk),
        .rstN(rstN),
        .runEn(runEn),
        .stepPulse(stepPulse),
        .phaseA(phaseA),
        .phaseB(phaseB),
        .phaseC(phaseC)
    );

    dataMemory memory0 (
        .clk(clk),
        .phaseA(phaseA),
        .pcWord(pcWord),
        .operandAddr(operandAddr),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadWord(loadWord),
        .storeStrobe(storeStrobe),
        .storeAddr(storeAddr),
        .storeWord(storeWord),
        .readWord(readWord)
    );

    syllableDecode decode0 (
        .clk(clk),
        .rstN(rstN),
        .phaseA(phaseA),
        .readWord(readWord),
        .pcSyl(pcSyl),
        .execOp(execOp),
        .operandAddr(operandAddr)
    );

    bufferRegister bufreg0 (
        .clk(clk),
        .rstN(rstN),
        .phaseB(phaseB),
        .phaseC(phaseC),
        .readWord(readWord),
        .execOp(execOp),
        .operandAddr(operandAddr),
        .acc(acc),
        .operandData(operandData),
        .parityError(parityError),
        .storeStrobe(storeStrobe),
        .storeAddr(storeAddr),
        .storeWord(storeWord)
    );

    arithExecute execute0 (
        .clk(clk),
        .rstN(rstN),
        .phaseC(phaseC),
        .execOp(execOp),
        .operandAddr(operandAddr),
        .operandData(operandData),
        .acc(acc),
        .pcWord(pcWord),
        .pcSyl(pcSyl)
    );

endmodule

`default_nettype wire

/* sim/lvdcTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lvdcTb import lvdcPkg::*; ();

    localparam int stepInstr = 26;
    localparam int runInstr = 24;
    localparam int loadCycles = 55;
    localparam int timeoutCycles = 3 * (stepInstr + runInstr) + loadCycles + 200;
    localparam logic [addrWidth-1:0] dataBase = 9'h100;

    logic clk = 1'b0;
    logic rstN;
    logic runEn;
    logic stepPulse;
    logic loadEn;
    logic [addrWidth-1:0] loadAddr;
    logic [wordWidth-1:0] loadWord;
    logic phaseC;
    logic [dataWidth-1:0] acc;
    logic [addrWidth-1:0] pcWord;
    logic pcSyl;
    logic storeStrobe;
    logic [addrWidth-1:0] storeAddr;
    logic [wordWidth-1:0] storeWord;
    logic parityError;

    // reference model.
    logic [wordWidth-1:0] modelMem [memDepth];
    logic [1:0] phaseCnt; // 0 idle, then A, B, C.
    logic [3:0] curOp;
    logic [addrWidth-1:0] curAddr;
    logic [dataWidth-1:0] expAcc;
    logic [addrWidth-1:0] expPcWord;
    logic expPcSyl;
    logic expParity;
    logic [wordWidth-1:0] fetchWord;
    logic [dataWidth-1:0] curOperand;
    logic [wordWidth-1:0] expStoreWord;
    logic expPhaseC;
    logic expStrobe;
    logic readsOperand;
    logic takeJump;
    integer seed;
    int cycleCount = 0;

    lvdcCore dut0 (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // 1 when the half has an even number of ones, so the 14 bits come out odd.
    function automatic logic parityBit(input logic [syllableWidth-1:0] half);
        int ones;
        ones = 0;
        for (int i = 0; i < syllableWidth; i++) begin
            ones += int'(half[i]);
        end
        return (ones % 2 == 0);
    endfunction

    function automatic logic [wordWidth-1:0] withParity(input logic [dataWidth-1:0] data);
        return {parityBit(data[dataWidth-1:syllableWidth]),
                parityBit(data[syllableWidth-1:0]), data};
    endfunction

    function automatic logic [3:0] pickOp(input logic [31:0] r);
        case (r % 7)
            0: return opAdd;
            1: return opSub;
            2: return opRsu;
            3: return opAnd;
            4: return opXor;
            5: return opCla;
            default: return opSto;
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expVal, gotVal);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic writeMem(input logic [addrWidth-1:0] addr, input logic [wordWidth-1:0] word);
        loadEn = 1'b1;
        loadAddr = addr;
        loadWord = word;
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    // syllable 0 runs first, so it is given first.
    task automatic loadPair(input logic [addrWidth-1:0] addr,
                            input logic [3:0] op0, input logic [addrWidth-1:0] a0,
                            input logic [3:0] op1, input logic [addrWidth-1:0] a1);
        writeMem(addr, withParity({op1, a1, op0, a0}));
    endtask

    task automatic stepOnce();
        stepPulse = 1'b1;
        @(negedge clk);
        stepPulse = 1'b0;
        while (!phaseC) begin
            @(negedge clk);
        end
        @(negedge clk); // results visible after phase C.
    endtask

    task automatic runFree(input int count);
        int seen;
        seen = 0;
        runEn = 1'b1;
        while (seen < count) begin
            @(negedge clk);
            if (phaseC) begin
                seen++;
            end
        end
        runEn = 1'b0; // the instruction in phase C is the last one.
        repeat (4) @(negedge clk);
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
    endtask

    assign fetchWord = modelMem[expPcWord];
    assign curOperand = modelMem[curAddr][dataWidth-1:0];
    assign expStoreWord = withParity(expAcc);
    assign expPhaseC = (phaseCnt == 2'd3);
    assign expStrobe = expPhaseC && (curOp == opSto);
    assign readsOperand = curOp inside {opAdd, opSub, opRsu, opAnd, opXor, opCla};

    always_comb begin
        case (curOp)
            opTra: takeJump = 1'b1;
            opTmi: takeJump = expAcc[dataWidth-1];
            opTnz: takeJump = (expAcc != '0);
            default: takeJump = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        if (loadEn) begin
            modelMem[loadAddr] <= loadWord;
        end
        if (!rstN) begin
            phaseCnt <= 2'd0;
            curOp <= opHop;
            curAddr <= '0;
            expAcc <= '0;
            expPcWord <= '0;
            expPcSyl <= 1'b0;
            expParity <= 1'b0;
        end else if (phaseCnt == 2'd0) begin
            if (runEn || stepPulse) begin
                phaseCnt <= 2'd1;
            end
        end else if (phaseCnt == 2'd1) begin
            curOp <= expPcSyl ? fetchWord[25:22] : fetchWord[12:9];
            curAddr <= expPcSyl ? fetchWord[21:13] : fetchWord[8:0];
            phaseCnt <= 2'd2;
        end else if (phaseCnt == 2'd2) begin
            if (readsOperand && withParity(curOperand) != modelMem[curAddr]) begin
                expParity <= 1'b1;
            end
            phaseCnt <= 2'd3;
        end else begin
            case (curOp)
                opAdd: expAcc <= expAcc + curOperand;
                opSub: expAcc <= expAcc - curOperand;
                opRsu: expAcc <= curOperand - expAcc;
                opAnd: expAcc <= expAcc & curOperand;
                opXor: expAcc <= expAcc ^ curOperand;
                opCla: expAcc <= curOperand;
                opSto: modelMem[curAddr] <= expStoreWord;
                default: begin
                end
            endcase
            expPcWord <= takeJump ? curAddr : expPcWord + addrWidth'(expPcSyl);
            expPcSyl <= !takeJump && !expPcSyl;
            phaseCnt <= runEn ? 2'd1 : 2'd0;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout: run went past %0d cycles", timeoutCycles);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) phaseC == expPhaseC)
        else reportMismatch("phaseC", 32'($sampled(expPhaseC)), 32'($sampled(phaseC)));
    assert property (@(posedge clk) disable iff (!rstN) acc == expAcc)
        else reportMismatch("acc", 32'($sampled(expAcc)), 32'($sampled(acc)));
    assert property (@(posedge clk) disable iff (!rstN) pcWord == expPcWord)
        else reportMismatch("pcWord", 32'($sampled(expPcWord)), 32'($sampled(pcWord)));
    assert property (@(posedge clk) disable iff (!rstN) pcSyl == expPcSyl)
        else reportMismatch("pcSyl", 32'($sampled(expPcSyl)), 32'($sampled(pcSyl)));
    assert property (@(posedge clk) disable iff (!rstN) storeStrobe == expStrobe)
        else reportMismatch("storeStrobe", 32'($sampled(expStrobe)), 32'($sampled(storeStrobe)));
    assert property (@(posedge clk) disable iff (!rstN) expStrobe |-> storeAddr == curAddr)
        else reportMismatch("storeAddr", 32'($sampled(curAddr)), 32'($sampled(storeAddr)));
    assert property (@(posedge clk) disable iff (!rstN) expStrobe |-> storeWord == expStoreWord)
        else reportMismatch("storeWord", 32'($sampled(expStoreWord)), 32'($sampled(storeWord)));
    assert property (@(posedge clk) disable iff (!rstN) parityError == expParity)
        else reportMismatch("parityError", 32'($sampled(expParity)), 32'($sampled(parityError)));

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd1;
        seed = 32'ha1a67f1b;
        rstN = 1'b0;
        runEn = 1'b0;
        stepPulse = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadWord = '0;
        applyReset();
        repeat (5) @(negedge clk); // nothing may move while idle.

        for (int i = 0; i < 7; i++) begin
            rnd = $random(seed);
            writeMem(dataBase + addrWidth'(i), withParity(rnd[dataWidth-1:0]));
        end
        writeMem(dataBase + 9'd7, withParity('0));
        rnd = $random(seed);
        writeMem(dataBase + 9'd8, withParity({1'b1, rnd[dataWidth-2:0]})); // negative.
        rnd = $random(seed);
        writeMem(dataBase + 9'd9, withParity(rnd[dataWidth-1:0]) ^ 28'h4000000);

        loadPair(9'd0, opCla, dataBase, opAdd, dataBase + 9'd1);
        loadPair(9'd1, opSub, dataBase + 9'd2, opRsu, dataBase + 9'd3);
        loadPair(9'd2, opAnd, dataBase + 9'd4, opXor, dataBase + 9'd5);
        loadPair(9'd3, opSto, dataBase + 9'd6, opCla, dataBase + 9'd6);
        // the no-op points at the bad word but does not read it.
        loadPair(9'd4, opAdd, dataBase + 9'd1, opHop, dataBase + 9'd9);
        loadPair(9'd5, opMpy, 9'd0, opDiv, 9'd0);
        loadPair(9'd6, opMph, 9'd0, opPio, 9'd0);
        loadPair(9'd7, opShf, 9'd0, opTra, 9'd9);
        loadPair(9'd8, opCla, dataBase, opCla, dataBase); // jumped over.
        loadPair(9'd9, opCla, dataBase + 9'd7, opTnz, 9'd8);
        loadPair(9'd10, opTmi, 9'd8, opCla, dataBase + 9'd8);
        loadPair(9'd11, opTmi, 9'd13, opHop, 9'd0);
        loadPair(9'd12, opCla, dataBase, opHop, 9'd0);
        loadPair(9'd13, opTnz, 9'd15, opHop, 9'd0);
        loadPair(9'd14, opCla, dataBase, opHop, 9'd0);
        loadPair(9'd15, opCla, dataBase + 9'd9, opAdd, dataBase + 9'd1);
        loadPair(9'd16, opHop, 9'd0, opHop, 9'd0);
        repeat (stepInstr) stepOnce();
        assert (parityError === 1'b1) else begin
            $display("Parity error flag is not set after reading the bad operand word");
            $display("FAIL: see errors above");
            $fatal(1, "parity flag missing");
        end

        // free-run pass over a random straight-line program.
        applyReset();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            writeMem(dataBase + addrWidth'(i), withParity(rnd[dataWidth-1:0]));
        end
        for (int w = 0; w < runInstr / 2; w++) begin
            rnd = $random(seed);
            rnd1 = $random(seed);
            loadPair(addrWidth'(w), pickOp(rnd), dataBase + addrWidth'(rnd[11:8]),
                     pickOp(rnd1), dataBase + addrWidth'(rnd1[11:8]));
        end
        runFree(runInstr);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/lvdcPkg.sv
design/timingGen.sv
design/dataMemory.sv
design/syllableDecode.sv
design/bufferRegister.sv
design/arithExecute.sv
design/lvdcCore.sv
sim/lvdcTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= lvdcTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir

.PHONY: sim clean

# the simulator exits nonzero on $fatal, which fails this target.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
